//--- hw/video_pkg.sv
// Shared constants and the output pixel word for the video output stage
// Colour depth is fixed at 6 bits out, 4 bits from the game core
// Conversion coefficients are in 1/256 units and assume unsigned 6-bit RGB
// The pixel union is read as R/G/B or as Pr/Y/Pb in the same bit slots

package video_pkg;

    localparam int GAME_W  = 4;         // Native game colour depth
    localparam int COLOR_W = 6;         // Board and output colour depth
    localparam int NUM_CH  = 3;         // 0 red, 1 green, 2 blue

    // Chroma sits around mid scale
    localparam int CHROMA_MID = 32;

    // Luma weights
    localparam int Y_KR = 77;
    localparam int Y_KG = 150;
    localparam int Y_KB = 29;

    // Blue difference
    localparam int PB_KR = -43;
    localparam int PB_KG = -85;
    localparam int PB_KB = 128;

    // Red difference
    localparam int PR_KR = 128;
    localparam int PR_KG = -107;
    localparam int PR_KB = -21;

    // Same 18 bits, two readings; in YPbPr mode the red pin carries Pr
    typedef union packed {
        struct packed {
            logic [COLOR_W-1:0] r;
            logic [COLOR_W-1:0] g;
            logic [COLOR_W-1:0] b;
        } rgb;
        struct packed {
            logic [COLOR_W-1:0] pr;
            logic [COLOR_W-1:0] y;
            logic [COLOR_W-1:0] pb;
        } cmp;
    } vga_pixel_u;

endpackage

//--- hw/video_src_sel.sv
// Source selection between the native game picture and the board picture
// scandoubler_disable_i is a level and may change on any cycle
// Game syncs arrive active low, board syncs active high; all outputs active high
// One register stage, everything cleared by reset

`timescale 1ns/100ps

module video_src_sel (
    input  logic                             clk_rgb,
    input  logic                             reset_i,
    input  logic                             scandoubler_disable_i,
    input  logic                             ypbpr_i,
    input  logic [video_pkg::GAME_W-1:0]     game_r_i,
    input  logic [video_pkg::GAME_W-1:0]     game_g_i,
    input  logic [video_pkg::GAME_W-1:0]     game_b_i,
    input  logic [video_pkg::COLOR_W-1:0]    board_r_i,
    input  logic [video_pkg::COLOR_W-1:0]    board_g_i,
    input  logic [video_pkg::COLOR_W-1:0]    board_b_i,
    input  logic                             hs_i,
    input  logic                             vs_i,
    input  logic                             board_hsync_i,
    input  logic                             board_vsync_i,
    input  logic                             osd_act_i,
    input  logic                             osd_pix_i,
    output logic [video_pkg::COLOR_W-1:0]    ch_r_o,
    output logic [video_pkg::COLOR_W-1:0]    ch_g_o,
    output logic [video_pkg::COLOR_W-1:0]    ch_b_o,
    output logic                             sel_game_o,
    output logic                             ypbpr_o,
    output logic                             hsync_o,
    output logic                             vsync_o,
    output logic                             csync_o,
    output logic                             osd_act_o,
    output logic                             osd_pix_o
);

    logic hs_sel;
    logic vs_sel;

    // Repeat the top bits so full scale maps to full scale
    function automatic logic [video_pkg::COLOR_W-1:0] widen(
        input logic [video_pkg::GAME_W-1:0] c
    );
        return {c, c[video_pkg::GAME_W-1 -: video_pkg::COLOR_W - video_pkg::GAME_W]};
    endfunction

    assign hs_sel = scandoubler_disable_i ? ~hs_i : board_hsync_i;
    assign vs_sel = scandoubler_disable_i ? ~vs_i : board_vsync_i;

    always_ff @(posedge clk_rgb) begin
        if (reset_i) begin
            ch_r_o     <= '0;
            ch_g_o     <= '0;
            ch_b_o     <= '0;
            sel_game_o <= 1'b0;
            ypbpr_o    <= 1'b0;
            hsync_o    <= 1'b0;
            vsync_o    <= 1'b0;
            csync_o    <= 1'b0;
            osd_act_o  <= 1'b0;
            osd_pix_o  <= 1'b0;
        end else begin
            if (scandoubler_disable_i) begin
                ch_r_o <= widen(game_r_i);
                ch_g_o <= widen(game_g_i);
                ch_b_o <= widen(game_b_i);
            end else begin
                ch_r_o <= board_r_i;
                ch_g_o <= board_g_i;
                ch_b_o <= board_b_i;
            end
            sel_game_o <= scandoubler_disable_i;
            ypbpr_o    <= ypbpr_i;              // Carried along with its pixel
            hsync_o    <= hs_sel;
            vsync_o    <= vs_sel;
            csync_o    <= ~(hs_sel ^ vs_sel);   // High outside both sync pulses
            osd_act_o  <= osd_act_i;
            osd_pix_o  <= osd_pix_i;
        end
    end

endmodule

//--- hw/color_chan.sv
// One colour channel with the on-screen-display overlay
// Inside the OSD window the picture is dimmed to a quarter
// and the two top bits come from the OSD pixel
// osd_pix_i must only be high inside the OSD window

`timescale 1ns/100ps

module color_chan (
    input  logic                             clk_rgb,
    input  logic                             reset_i,
    input  logic [video_pkg::COLOR_W-1:0]    chan_i,
    input  logic                             osd_act_i,
    input  logic                             osd_pix_i,
    output logic [video_pkg::COLOR_W-1:0]    chan_o
);

    logic [video_pkg::COLOR_W-1:0] overlay;

    // Background shows through at low level behind the text
    assign overlay = {{2{osd_pix_i}}, chan_i[video_pkg::COLOR_W-1:2]};

    always_ff @(posedge clk_rgb) begin
        if (reset_i) begin
            chan_o <= '0;
        end else if (osd_act_i) begin
            chan_o <= overlay;
        end else begin
            chan_o <= chan_i;      // Outside the window
        end
    end

    // An OSD pixel outside the OSD window means the source is misaligned
    a_pix_inside_window: assert property (
        @(posedge clk_rgb) disable iff (reset_i)
        !(osd_pix_i && !osd_act_i)
    ) else $error("OSD pixel set outside the OSD window");

endmodule

//--- hw/ypbpr_conv.sv
// Output format and sync mode selection
// YPbPr uses integer coefficients in 1/256 units with arithmetic shifts,
// so results may be one code off a floating point converter
// Composite sync goes out on the HS pin with VS held high for the game
// path and for YPbPr, as SCART style cables expect
// Inputs must be aligned to the same pixel; one register stage

`timescale 1ns/100ps

module ypbpr_conv (
    input  logic                             clk_rgb,
    input  logic                             reset_i,
    input  logic [video_pkg::COLOR_W-1:0]    r_i,
    input  logic [video_pkg::COLOR_W-1:0]    g_i,
    input  logic [video_pkg::COLOR_W-1:0]    b_i,
    input  logic                             ypbpr_i,
    input  logic                             sel_game_i,
    input  logic                             hsync_i,
    input  logic                             vsync_i,
    input  logic                             csync_i,
    output video_pkg::vga_pixel_u            pix_o,
    output logic                             vga_hs_o,
    output logic                             vga_vs_o
);

    logic signed [video_pkg::COLOR_W+1:0] r_s;
    logic signed [video_pkg::COLOR_W+1:0] g_s;
    logic signed [video_pkg::COLOR_W+1:0] b_s;
    int y_sum;
    int pb_sum;
    int pr_sum;
    int y_val;
    int pb_val;
    int pr_val;
    logic use_csync;

    always_comb begin
        // Zero extend so the products stay signed
        r_s = $signed({2'b00, r_i});
        g_s = $signed({2'b00, g_i});
        b_s = $signed({2'b00, b_i});

        y_sum  = video_pkg::Y_KR  * r_s + video_pkg::Y_KG  * g_s + video_pkg::Y_KB  * b_s;
        pb_sum = video_pkg::PB_KR * r_s + video_pkg::PB_KG * g_s + video_pkg::PB_KB * b_s;
        pr_sum = video_pkg::PR_KR * r_s + video_pkg::PR_KG * g_s + video_pkg::PR_KB * b_s;

        y_val  = y_sum >>> 8;                               // 0 to 63
        pb_val = video_pkg::CHROMA_MID + (pb_sum >>> 8);    // Stays within 0 to 63
        pr_val = video_pkg::CHROMA_MID + (pr_sum >>> 8);
    end

    assign use_csync = sel_game_i | ypbpr_i;

    always_ff @(posedge clk_rgb) begin
        if (reset_i) begin
            pix_o    <= '0;
            vga_hs_o <= 1'b0;
            vga_vs_o <= 1'b0;
        end else begin
            if (ypbpr_i) begin
                pix_o.cmp.pr <= pr_val[video_pkg::COLOR_W-1:0];
                pix_o.cmp.y  <= y_val[video_pkg::COLOR_W-1:0];
                pix_o.cmp.pb <= pb_val[video_pkg::COLOR_W-1:0];
            end else begin
                pix_o.rgb.r <= r_i;
                pix_o.rgb.g <= g_i;
                pix_o.rgb.b <= b_i;
            end
            vga_hs_o <= use_csync ? csync_i : hsync_i;
            vga_vs_o <= use_csync ? 1'b1    : vsync_i;  // High selects RGB on SCART
        end
    end

    // Monitor must never see a VS pulse while composite sync is in use
    a_vs_high_on_csync: assert property (
        @(posedge clk_rgb) disable iff (reset_i)
        use_csync |=> vga_vs_o
    ) else $error("VS not held high in composite sync mode");

endmodule

//--- hw/video_out_top.sv
// Video output stage of the board wrapper
// All inputs are levels sampled on every clk_rgb edge, no handshake
// Fixed latency of 3 clk_rgb cycles for pixels, syncs and mode bits
// Outputs read as zero for 3 cycles after reset
// The OSD arrives as ready made per-pixel levels

`timescale 1ns/100ps

module video_out_top (
    input  logic                             clk_rgb,
    input  logic                             reset_i,
    input  logic                             scandoubler_disable_i,
    input  logic                             ypbpr_i,
    input  logic [video_pkg::GAME_W-1:0]     game_r_i,
    input  logic [video_pkg::GAME_W-1:0]     game_g_i,
    input  logic [video_pkg::GAME_W-1:0]     game_b_i,
    input  logic [video_pkg::COLOR_W-1:0]    board_r_i,
    input  logic [video_pkg::COLOR_W-1:0]    board_g_i,
    input  logic [video_pkg::COLOR_W-1:0]    board_b_i,
    input  logic                             hs_i,
    input  logic                             vs_i,
    input  logic                             board_hsync_i,
    input  logic                             board_vsync_i,
    input  logic                             osd_act_i,
    input  logic                             osd_pix_i,
    output logic [video_pkg::COLOR_W-1:0]    vga_r_o,
    output logic [video_pkg::COLOR_W-1:0]    vga_g_o,
    output logic [video_pkg::COLOR_W-1:0]    vga_b_o,
    output logic                             vga_hs_o,
    output logic                             vga_vs_o
);

    logic [video_pkg::COLOR_W-1:0] ch_in  [video_pkg::NUM_CH];
    logic [video_pkg::COLOR_W-1:0] ch_out [video_pkg::NUM_CH];
    logic sel_game, ypbpr, hsync, vsync, csync, osd_act, osd_pix;
    logic sel_game_q, ypbpr_q, hsync_q, vsync_q, csync_q;
    video_pkg::vga_pixel_u pix;

    video_src_sel u_src_sel (
        .clk_rgb               ( clk_rgb               ),
        .reset_i               ( reset_i               ),
        .scandoubler_disable_i ( scandoubler_disable_i ),
        .ypbpr_i               ( ypbpr_i               ),
        .game_r_i              ( game_r_i              ),
        .game_g_i              ( game_g_i              ),
        .game_b_i              ( game_b_i              ),
        .board_r_i             ( board_r_i             ),
        .board_g_i             ( board_g_i             ),
        .board_b_i             ( board_b_i             ),
        .hs_i                  ( hs_i                  ),
        .vs_i                  ( vs_i                  ),
        .board_hsync_i         ( board_hsync_i         ),
        .board_vsync_i         ( board_vsync_i         ),
        .osd_act_i             ( osd_act_i             ),
        .osd_pix_i             ( osd_pix_i             ),
        .ch_r_o                ( ch_in[0]              ),
        .ch_g_o                ( ch_in[1]              ),
        .ch_b_o                ( ch_in[2]              ),
        .sel_game_o            ( sel_game              ),
        .ypbpr_o               ( ypbpr                 ),
        .hsync_o               ( hsync                 ),
        .vsync_o               ( vsync                 ),
        .csync_o               ( csync                 ),
        .osd_act_o             ( osd_act               ),
        .osd_pix_o             ( osd_pix               )
    );

    for (genvar i = 0; i < video_pkg::NUM_CH; i++) begin : g_chan
        color_chan u_color_chan (
            .clk_rgb   ( clk_rgb   ),
            .reset_i   ( reset_i   ),
            .chan_i    ( ch_in[i]  ),
            .osd_act_i ( osd_act   ),
            .osd_pix_i ( osd_pix   ),
            .chan_o    ( ch_out[i] )
        );
    end

    // Sideband follows the channel stage
    always_ff @(posedge clk_rgb) begin
        if (reset_i) begin
            sel_game_q <= 1'b0;
            ypbpr_q    <= 1'b0;
            hsync_q    <= 1'b0;
            vsync_q    <= 1'b0;
            csync_q    <= 1'b0;
        end else begin
            sel_game_q <= sel_game;
            ypbpr_q    <= ypbpr;
            hsync_q    <= hsync;
            vsync_q    <= vsync;
            csync_q    <= csync;
        end
    end

    ypbpr_conv u_ypbpr_conv (
        .clk_rgb    ( clk_rgb    ),
        .reset_i    ( reset_i    ),
        .r_i        ( ch_out[0]  ),
        .g_i        ( ch_out[1]  ),
        .b_i        ( ch_out[2]  ),
        .ypbpr_i    ( ypbpr_q    ),
        .sel_game_i ( sel_game_q ),
        .hsync_i    ( hsync_q    ),
        .vsync_i    ( vsync_q    ),
        .csync_i    ( csync_q    ),
        .pix_o      ( pix        ),
        .vga_hs_o   ( vga_hs_o   ),
        .vga_vs_o   ( vga_vs_o   )
    );

    // Pr, Y, Pb share the R, G, B pins
    assign vga_r_o = pix.rgb.r;
    assign vga_g_o = pix.rgb.g;
    assign vga_b_o = pix.rgb.b;

endmodule

//--- dv/video_out_tb.sv
// Testbench for the video output stage
// Every input gets a fresh random level each cycle, so syncs are bit patterns
// rather than real line timing; only the sync mapping is checked
// Expected pins come from a 3-stage model pipe that clears with reset

`timescale 1ns/100ps

module video_out_tb;

    localparam int LATENCY    = 3;
    localparam int RUN_CYCLES = 300;
    localparam int WAIT_LIMIT = 20;     // Cycles allowed for data to reach the pins
    localparam int PIN_W      = 2 + 3 * video_pkg::COLOR_W;

    logic clk_rgb;
    logic reset_i;
    logic scandoubler_disable_i;
    logic ypbpr_i;
    logic [video_pkg::GAME_W-1:0]  game_r_i, game_g_i, game_b_i;
    logic [video_pkg::COLOR_W-1:0] board_r_i, board_g_i, board_b_i;
    logic hs_i, vs_i, board_hsync_i, board_vsync_i;
    logic osd_act_i, osd_pix_i;
    logic [video_pkg::COLOR_W-1:0] vga_r_o, vga_g_o, vga_b_o;
    logic vga_hs_o, vga_vs_o;

    logic [PIN_W-1:0] exp_q [LATENCY];     // {hs, vs, r, g, b}
    logic vld_q [LATENCY];
    logic csync_mode_q [LATENCY];
    logic [PIN_W-1:0] dut_word;
    logic check_en;
    logic [31:0] rng_state;
    int mismatch_count;
    int tests_passed;
    int tests_failed;
    int errs_before;

    video_out_top u_video_out_top (
        .clk_rgb               ( clk_rgb               ),
        .reset_i               ( reset_i               ),
        .scandoubler_disable_i ( scandoubler_disable_i ),
        .ypbpr_i               ( ypbpr_i               ),
        .game_r_i              ( game_r_i              ),
        .game_g_i              ( game_g_i              ),
        .game_b_i              ( game_b_i              ),
        .board_r_i             ( board_r_i             ),
        .board_g_i             ( board_g_i             ),
        .board_b_i             ( board_b_i             ),
        .hs_i                  ( hs_i                  ),
        .vs_i                  ( vs_i                  ),
        .board_hsync_i         ( board_hsync_i         ),
        .board_vsync_i         ( board_vsync_i         ),
        .osd_act_i             ( osd_act_i             ),
        .osd_pix_i             ( osd_pix_i             ),
        .vga_r_o               ( vga_r_o               ),
        .vga_g_o               ( vga_g_o               ),
        .vga_b_o               ( vga_b_o               ),
        .vga_hs_o              ( vga_hs_o              ),
        .vga_vs_o              ( vga_vs_o              )
    );

    assign dut_word = {vga_hs_o, vga_vs_o, vga_r_o, vga_g_o, vga_b_o};

    initial begin
        clk_rgb = 1'b0;
        forever #2 clk_rgb = ~clk_rgb;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Dim to a quarter, OSD pixel on the two top bits
    function automatic logic [5:0] osd_mix(input logic [5:0] c, input logic oa, input logic op);
        return oa ? {op, op, c[5:2]} : c;
    endfunction

    // Pins expected three cycles after one input sample
    function automatic logic [PIN_W-1:0] expect_pins(
        input logic sd, input logic yp,
        input logic [3:0] gr, input logic [3:0] gg, input logic [3:0] gb,
        input logic [5:0] br, input logic [5:0] bg, input logic [5:0] bb,
        input logic hs, input logic vs, input logic bhs, input logic bvs,
        input logic oa, input logic op
    );
        int r, g, b, y, pb, pr;
        logic h, v, cs;
        logic [5:0] p0, p1, p2;
        r = osd_mix(sd ? {gr, gr[3:2]} : br, oa, op);
        g = osd_mix(sd ? {gg, gg[3:2]} : bg, oa, op);
        b = osd_mix(sd ? {gb, gb[3:2]} : bb, oa, op);
        h = sd ? ~hs : bhs;
        v = sd ? ~vs : bvs;
        cs = ~(h ^ v);
        if (yp) begin
            y  = (video_pkg::Y_KR * r + video_pkg::Y_KG * g + video_pkg::Y_KB * b) >>> 8;
            pb = 32 + ((video_pkg::PB_KR * r + video_pkg::PB_KG * g + video_pkg::PB_KB * b) >>> 8);
            pr = 32 + ((video_pkg::PR_KR * r + video_pkg::PR_KG * g + video_pkg::PR_KB * b) >>> 8);
            p0 = pr[5:0];   // Pr on the red pin
            p1 = y[5:0];
            p2 = pb[5:0];
        end else begin
            p0 = r[5:0];
            p1 = g[5:0];
            p2 = b[5:0];
        end
        if (sd || yp) begin
            return {cs, 1'b1, p0, p1, p2};
        end
        return {h, v, p0, p1, p2};
    endfunction

    always @(posedge clk_rgb) begin
        if (reset_i) begin
            for (int i = 0; i < LATENCY; i++) begin
                exp_q[i]        <= '0;
                vld_q[i]        <= 1'b0;
                csync_mode_q[i] <= 1'b0;
            end
        end else begin
            exp_q[0] <= expect_pins(scandoubler_disable_i, ypbpr_i, game_r_i, game_g_i,
                                    game_b_i, board_r_i, board_g_i, board_b_i, hs_i, vs_i,
                                    board_hsync_i, board_vsync_i, osd_act_i, osd_pix_i);
            vld_q[0]        <= 1'b1;
            csync_mode_q[0] <= scandoubler_disable_i | ypbpr_i;
            for (int i = 1; i < LATENCY; i++) begin
                exp_q[i]        <= exp_q[i-1];
                vld_q[i]        <= vld_q[i-1];
                csync_mode_q[i] <= csync_mode_q[i-1];
            end
        end
    end

    a_pins_match: assert property (
        @(posedge clk_rgb) check_en |-> dut_word == exp_q[LATENCY-1]
    ) else begin
        mismatch_count++;
        $display("Mismatch at %0t: pins %h, expected %h", $time,
                 $sampled(dut_word), $sampled(exp_q[LATENCY-1]));
    end

    a_zero_before_data: assert property (
        @(posedge clk_rgb) (check_en && !vld_q[LATENCY-1]) |-> dut_word == '0
    ) else begin
        mismatch_count++;
        $display("Mismatch at %0t: pins %h not zero before fresh data", $time,
                 $sampled(dut_word));
    end

    a_vs_held: assert property (
        @(posedge clk_rgb) (check_en && csync_mode_q[LATENCY-1]) |-> vga_vs_o
    ) else begin
        mismatch_count++;
        $display("Mismatch at %0t: vga_vs_o low in composite sync mode", $time);
    end

    // sd_mode 0 low, 1 high, 2 random per cycle
    task automatic drive_inputs(input int sd_mode, input logic yp, input logic osd_en);
        logic [31:0] a;
        logic [31:0] b;
        rng_state = xorshift32(rng_state);
        a = rng_state;
        rng_state = xorshift32(rng_state);
        b = rng_state;
        scandoubler_disable_i = (sd_mode == 2) ? b[6] : (sd_mode == 1);
        ypbpr_i       = yp;
        game_r_i      = a[3:0];
        game_g_i      = a[7:4];
        game_b_i      = a[11:8];
        board_r_i     = a[17:12];
        board_g_i     = a[23:18];
        board_b_i     = a[29:24];
        hs_i          = b[0];
        vs_i          = b[1];
        board_hsync_i = b[2];
        board_vsync_i = b[3];
        osd_act_i     = osd_en & b[4];
        osd_pix_i     = osd_en & b[4] & b[5];   // Only inside the window
    endtask

    task automatic drive_cycles(input int sd_mode, input logic yp, input logic osd_en,
                                input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk_rgb);
            #1;
            drive_inputs(sd_mode, yp, osd_en);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_rgb);
        #1;
        reset_i = 1'b1;
        drive_cycles(2, 1'b0, 1'b1, 4);    // Inputs keep moving under reset
        reset_i = 1'b0;
    endtask

    task automatic wait_for_data();
        int waited;
        waited = 0;
        while (!vld_q[LATENCY-1] && waited < WAIT_LIMIT) begin
            @(posedge clk_rgb);
            #1;
            waited++;
        end
        if (!vld_q[LATENCY-1]) begin
            $display("Timeout: no fresh data reached the outputs after reset");
            $display("Test failed");
            $finish;
        end
    endtask

    // Let the last samples reach the pins before judging the test
    task automatic finish_test(input string name, input int errs_at_start);
        for (int n = 0; n <= LATENCY; n++) begin
            @(posedge clk_rgb);
            #1;
        end
        if (mismatch_count == errs_at_start) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL, %0d mismatches", name, mismatch_count - errs_at_start);
        end
    endtask

    initial begin
        rng_state      = 32'h4744;
        mismatch_count = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        check_en       = 1'b0;
        reset_i        = 1'b1;
        scandoubler_disable_i = 1'b0;
        ypbpr_i        = 1'b0;
        game_r_i       = '0;
        game_g_i       = '0;
        game_b_i       = '0;
        board_r_i      = '0;
        board_g_i      = '0;
        board_b_i      = '0;
        hs_i           = 1'b1;
        vs_i           = 1'b1;
        board_hsync_i  = 1'b0;
        board_vsync_i  = 1'b0;
        osd_act_i      = 1'b0;
        osd_pix_i      = 1'b0;

        for (int n = 0; n < 4; n++) begin
            @(posedge clk_rgb);
            #1;
            check_en = 1'b1;   // Pins are known once the first edge cleared them
        end
        reset_i = 1'b0;
        wait_for_data();

        errs_before = mismatch_count;
        drive_cycles(0, 1'b0, 1'b0, RUN_CYCLES);
        finish_test("board_rgb", errs_before);

        errs_before = mismatch_count;
        drive_cycles(1, 1'b0, 1'b0, RUN_CYCLES);
        finish_test("game_path", errs_before);

        errs_before = mismatch_count;
        drive_cycles(2, 1'b0, 1'b1, RUN_CYCLES);
        finish_test("osd_overlay", errs_before);

        errs_before = mismatch_count;
        drive_cycles(2, 1'b1, 1'b1, RUN_CYCLES);
        finish_test("ypbpr", errs_before);

        errs_before = mismatch_count;
        drive_cycles(2, 1'b1, 1'b1, 20);
        apply_reset();
        wait_for_data();
        drive_cycles(2, 1'b0, 1'b1, 50);
        finish_test("mid_run_reset", errs_before);

        $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, mismatch_count);
        if (tests_failed == 0 && mismatch_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- video_out_top.f
hw/video_pkg.sv
hw/video_src_sel.sv
hw/color_chan.sv
hw/ypbpr_conv.sv
hw/video_out_top.sv
dv/video_out_tb.sv
